// File: hw/nf_uart.sv
/*
 * Top level of the UART peripheral: register block on the word bus,
 * transmitter on uart_tx and receiver on uart_rx.
 */
`timescale 1ns/1ps
`default_nettype none

`include "nf_uart_config.svh"

module nf_uart
    import nf_uart_frame_pkg::*;
(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic [1:0]                  addr,
    input  logic                        we,
    input  logic                        re,
    input  logic [`NF_UART_BUS_W-1:0]   wd,
    output logic [`NF_UART_BUS_W-1:0]   rd,
    output logic                        uart_tx,
    input  logic                        uart_rx
);

    logic                           tr_en;
    logic                           rec_en;
    logic [`NF_UART_COMP_W-1:0]     comp;
    uart_byte_t                     tx_data;
    logic                           req;
    logic                           req_ack;
    logic                           tx_idle;
    uart_rx_frame_t                 rx_frame;
    logic                           rx_done;

    nf_uart_regs u_regs (
        .clk      (clk),
        .resetn   (resetn),
        .addr     (addr),
        .we       (we),
        .re       (re),
        .wd       (wd),
        .rd       (rd),
        .tr_en    (tr_en),
        .rec_en   (rec_en),
        .comp     (comp),
        .tx_data  (tx_data),
        .req      (req),
        .req_ack  (req_ack),
        .tx_idle  (tx_idle),
        .rx_frame (rx_frame),
        .rx_done  (rx_done)
    );

    nf_uart_transmitter u_tx (
        .clk        (clk),
        .resetn     (resetn),
        .tr_en      (tr_en),
        .comp       (comp),
        .tx_data    (tx_data),
        .req        (req),
        .req_ack    (req_ack),
        .idle_state (tx_idle),
        .uart_tx    (uart_tx)
    );

    nf_uart_receiver u_rx (
        .clk      (clk),
        .resetn   (resetn),
        .rec_en   (rec_en),
        .comp     (comp),
        .uart_rx  (uart_rx),
        .rx_frame (rx_frame),
        .rx_done  (rx_done)
    );

endmodule

`default_nettype wire

// File: hw/nf_uart_config.svh
/*
 * Build-time sizes and reset values of the UART peripheral.
 * Include this wherever a data, compare or bus width is needed.
 */
`ifndef NF_UART_CONFIG_SVH
`define NF_UART_CONFIG_SVH

`define NF_UART_DATA_W      8       // bits per serial character
`define NF_UART_COMP_W      16      // baud compare value width
`define NF_UART_BUS_W       32      // processor bus data width
`define NF_UART_COMP_RST    16'd15  // baud compare after reset

`endif

// File: hw/nf_uart_frame_pkg.sv
/*
 * Serial-frame types shared by the transmitter, the receiver and the
 * register block. Import with a wildcard in the module header.
 */
`default_nettype none

`include "nf_uart_config.svh"

package nf_uart_frame_pkg;

    typedef logic [`NF_UART_DATA_W-1:0] uart_byte_t;

    // what the receiver hands over at the end of a frame
    typedef struct packed {
        uart_byte_t data;
        logic       frame_err;  // stop bit sampled low
    } uart_rx_frame_t;

    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_TRANSMIT, TX_STOP, TX_WAIT
    } uart_tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_RECEIVE, RX_STOP
    } uart_rx_state_t;

endpackage

`default_nettype wire

// File: hw/nf_uart_holding_reg.sv
/*
 * One-entry holding register with a full flag. load stores din and
 * sets full, take clears full; load wins when both are asserted.
 */
`timescale 1ns/1ps
`default_nettype none

module nf_uart_holding_reg
#(
    parameter type payload_t = logic [7:0]
)
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     load,
    input  payload_t din,
    input  logic     take,
    output payload_t dout,
    output logic     full
);

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            full <= 1'b0;
            dout <= '0;  // status fields read back as zero
        end
        else if (load)
        begin
            full <= 1'b1;
            dout <= din;
        end
        else if (take)
            full <= 1'b0;
    end

endmodule

`default_nettype wire

// File: hw/nf_uart_receiver.sv
/*
 * UART receiver: synchronizes uart_rx, validates the start bit at its
 * midpoint, then samples data LSB first and the stop bit once per
 * comp+1 clocks. rx_done pulses with the frame and its framing flag.
 */
`timescale 1ns/1ps
`default_nettype none

`include "nf_uart_config.svh"

module nf_uart_receiver
    import nf_uart_frame_pkg::*;
(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        rec_en,     // receiver enable
    input  logic [`NF_UART_COMP_W-1:0]  comp,       // baud compare value
    input  logic                        uart_rx,    // asynchronous line
    output uart_rx_frame_t              rx_frame,
    output logic                        rx_done     // one-cycle pulse
);

    localparam int BIT_CNT_W = $clog2(`NF_UART_DATA_W);

    uart_rx_state_t                 state;
    uart_rx_state_t                 next_state;
    logic [1:0]                     rx_sync;      // two-flop synchronizer
    logic                           rx_s;
    logic                           rx_last;      // for edge detect
    logic                           start_fall;
    logic [`NF_UART_COMP_W-1:0]     counter;
    logic [BIT_CNT_W-1:0]           bit_counter;
    logic                           half_tick;
    logic                           full_tick;
    logic                           last_bit;
    uart_byte_t                     shift_reg;

    assign rx_s       = rx_sync[1];
    assign start_fall = rx_last & ~rx_s;
    assign half_tick  = counter >= (comp >> 1);
    assign full_tick  = counter >= comp;
    assign last_bit   = bit_counter == BIT_CNT_W'(`NF_UART_DATA_W - 1);

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            rx_sync <= 2'b11;  // idle line level
            rx_last <= 1'b1;
        end
        else
        begin
            rx_sync <= {rx_sync[0], uart_rx};
            rx_last <= rx_s;
        end
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            state <= RX_IDLE;
        else if (!rec_en)
            state <= RX_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            RX_IDLE:
                if (start_fall)
                    next_state = RX_START;
            RX_START:
                if (half_tick)
                    next_state = rx_s ? RX_IDLE : RX_RECEIVE;  // high again is a glitch
            RX_RECEIVE:
                if (full_tick && last_bit)
                    next_state = RX_STOP;
            RX_STOP:
                if (full_tick)
                    next_state = RX_IDLE;
            default:
                next_state = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            counter     <= '0;
            bit_counter <= '0;
            rx_done     <= 1'b0;
        end
        else if (!rec_en)
        begin
            counter     <= '0;
            bit_counter <= '0;
            rx_done     <= 1'b0;
        end
        else
        begin
            rx_done <= 1'b0;
            case (state)
                RX_START:
                    counter <= half_tick ? '0 : counter + 1'b1;
                RX_RECEIVE:
                begin
                    counter <= full_tick ? '0 : counter + 1'b1;
                    if (full_tick)
                        bit_counter <= bit_counter + 1'b1;  // wraps after last bit
                end
                RX_STOP:
                begin
                    counter <= full_tick ? '0 : counter + 1'b1;
                    if (full_tick)
                        rx_done <= 1'b1;
                end
                default:
                begin
                    counter     <= '0;
                    bit_counter <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == RX_RECEIVE && full_tick)
            shift_reg <= {rx_s, shift_reg[`NF_UART_DATA_W-1:1]};  // lsb first
        if (state == RX_STOP && full_tick)
        begin
            rx_frame.data      <= shift_reg;
            rx_frame.frame_err <= ~rx_s;  // stop bit must be high
        end
    end

endmodule

`default_nettype wire

// File: hw/nf_uart_regs.sv
/*
 * Bus register block of the UART. Holds the enables and the baud
 * compare value, one byte per direction, and builds the status word.
 * Writes act on the strobe edge; read data follows addr combinationally.
 */
`timescale 1ns/1ps
`default_nettype none

`include "nf_uart_config.svh"

module nf_uart_regs
    import nf_uart_frame_pkg::*, nf_uart_regs_pkg::*;
(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic [1:0]                  addr,
    input  logic                        we,
    input  logic                        re,
    input  logic [`NF_UART_BUS_W-1:0]   wd,
    output logic [`NF_UART_BUS_W-1:0]   rd,
    output logic                        tr_en,
    output logic                        rec_en,
    output logic [`NF_UART_COMP_W-1:0]  comp,
    output uart_byte_t                  tx_data,
    output logic                        req,       // tx holding full
    input  logic                        req_ack,
    input  logic                        tx_idle,
    input  uart_rx_frame_t              rx_frame,
    input  logic                        rx_done
);

    logic                       tx_busy;
    logic                       tx_load;
    logic                       tx_take;
    logic                       rx_take;
    logic                       rx_valid;
    uart_rx_frame_t             rx_hold;
    logic [`NF_UART_BUS_W-1:0]  ctrl_rd;

    assign tx_busy = req | ~tx_idle;
    assign tx_load = we && addr == REG_TXDATA && !tx_busy;  // dropped while busy
    assign tx_take = req_ack | ~tr_en;                      // disable empties it
    assign rx_take = re && addr == REG_RXDATA;

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            tr_en  <= 1'b0;
            rec_en <= 1'b0;
            comp   <= `NF_UART_COMP_RST;
        end
        else if (we)
        begin
            if (addr == REG_CTRL)
            begin
                tr_en  <= wd[CTRL_TR_EN];
                rec_en <= wd[CTRL_REC_EN];
            end
            if (addr == REG_COMP)
                comp <= wd[`NF_UART_COMP_W-1:0];
        end
    end

    nf_uart_holding_reg #(.payload_t(uart_byte_t)) u_tx_hold (
        .clk    (clk),
        .resetn (resetn),
        .load   (tx_load),
        .din    (wd[`NF_UART_DATA_W-1:0]),
        .take   (tx_take),
        .dout   (tx_data),
        .full   (req)
    );

    nf_uart_holding_reg #(.payload_t(uart_rx_frame_t)) u_rx_hold (
        .clk    (clk),
        .resetn (resetn),
        .load   (rx_done),
        .din    (rx_frame),
        .take   (rx_take),
        .dout   (rx_hold),
        .full   (rx_valid)
    );

    always_comb
    begin
        ctrl_rd                 = '0;
        ctrl_rd[CTRL_TR_EN]     = tr_en;
        ctrl_rd[CTRL_REC_EN]    = rec_en;
        ctrl_rd[CTRL_TX_BUSY]   = tx_busy;
        ctrl_rd[CTRL_RX_VALID]  = rx_valid;
        ctrl_rd[CTRL_FRAME_ERR] = rx_hold.frame_err;  // of the last frame
    end

    always_comb
    begin
        case (uart_reg_addr_t'(addr))
            REG_CTRL:   rd = ctrl_rd;
            REG_RXDATA: rd = `NF_UART_BUS_W'(rx_hold.data);
            REG_COMP:   rd = `NF_UART_BUS_W'(comp);
            default:    rd = '0;  // TXDATA is write only
        endcase
    end

endmodule

`default_nettype wire

// File: hw/nf_uart_regs_pkg.sv
/*
 * Register map of the UART peripheral: word addresses and the bit
 * layout of the control/status register. Shared by the register block,
 * the top level and the testbench.
 */
`default_nettype none

package nf_uart_regs_pkg;

    // word addresses on the bus
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,  // enables, status on read
        REG_TXDATA = 2'd1,  // write only
        REG_RXDATA = 2'd2,  // read, byte in bits 7:0
        REG_COMP   = 2'd3   // baud compare value
    } uart_reg_addr_t;

    // field positions inside REG_CTRL
    typedef enum int {
        CTRL_TR_EN     = 0,  // rw
        CTRL_REC_EN    = 1,  // rw
        CTRL_TX_BUSY   = 2,  // ro
        CTRL_RX_VALID  = 3,  // ro
        CTRL_FRAME_ERR = 4   // ro
    } uart_ctrl_bit_e;

endpackage

`default_nettype wire

// File: hw/nf_uart_transmitter.sv
/*
 * UART transmitter: sends one character per request as start bit,
 * data LSB first and stop bit, each comp+1 clocks long. The byte is
 * taken when the FSM leaves idle; req_ack pulses once the stop bit ends.
 */
`timescale 1ns/1ps
`default_nettype none

`include "nf_uart_config.svh"

module nf_uart_transmitter
    import nf_uart_frame_pkg::*;
(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        tr_en,       // transmitter enable
    input  logic [`NF_UART_COMP_W-1:0]  comp,        // baud compare value
    input  uart_byte_t                  tx_data,     // byte to send
    input  logic                        req,         // held until acknowledged
    output logic                        req_ack,     // one-cycle pulse
    output logic                        idle_state,
    output logic                        uart_tx
);

    localparam int BIT_CNT_W = $clog2(`NF_UART_DATA_W) + 1;

    uart_tx_state_t                 state;
    uart_tx_state_t                 next_state;
    uart_byte_t                     int_reg;      // byte being shifted out
    logic [BIT_CNT_W-1:0]           bit_counter;
    logic [`NF_UART_COMP_W-1:0]     counter;      // shared baud counter
    logic                           baud_tick;
    logic                           last_bit;

    assign baud_tick  = counter >= comp;
    assign last_bit   = bit_counter == BIT_CNT_W'(`NF_UART_DATA_W);
    assign idle_state = state == TX_IDLE;

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            state <= TX_IDLE;
        else if (!tr_en)
            state <= TX_IDLE;  // disable aborts the frame
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            TX_IDLE:     if (req)       next_state = TX_START;
            TX_START:    if (baud_tick) next_state = TX_TRANSMIT;
            TX_TRANSMIT: if (last_bit)  next_state = TX_STOP;
            TX_STOP:     if (baud_tick) next_state = TX_WAIT;
            TX_WAIT:     if (req_ack)   next_state = TX_IDLE;
            default:                    next_state = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            bit_counter <= '0;
            counter     <= '0;
            uart_tx     <= 1'b1;
            req_ack     <= 1'b0;
        end
        else if (!tr_en)
        begin
            bit_counter <= '0;
            counter     <= '0;
            uart_tx     <= 1'b1;  // line back to idle level
            req_ack     <= 1'b0;
        end
        else
        begin
            req_ack <= 1'b0;
            case (state)
                TX_IDLE:
                begin
                    uart_tx     <= 1'b1;
                    bit_counter <= '0;
                    counter     <= '0;
                end
                TX_START:
                begin
                    uart_tx <= 1'b0;
                    counter <= baud_tick ? '0 : counter + 1'b1;
                end
                TX_TRANSMIT:
                begin
                    counter <= baud_tick ? '0 : counter + 1'b1;
                    if (last_bit)
                    begin
                        uart_tx     <= 1'b1;  // stop bit begins
                        bit_counter <= '0;
                    end
                    else
                    begin
                        uart_tx <= int_reg[bit_counter[BIT_CNT_W-2:0]];
                        if (baud_tick)
                            bit_counter <= bit_counter + 1'b1;
                    end
                end
                TX_STOP:
                begin
                    counter <= baud_tick ? '0 : counter + 1'b1;
                    if (baud_tick)
                        req_ack <= 1'b1;  // seen in TX_WAIT
                end
                default:
                begin
                    uart_tx <= 1'b1;
                end
            endcase
        end
    end

    // byte latched on the way out of idle
    always_ff @(posedge clk)
    begin
        if (tr_en && idle_state && req)
            int_reg <= tx_data;
    end

endmodule

`default_nettype wire

// File: nf_uart.f
+incdir+hw
hw/nf_uart_frame_pkg.sv
hw/nf_uart_regs_pkg.sv
hw/nf_uart_holding_reg.sv
hw/nf_uart_transmitter.sv
hw/nf_uart_receiver.sv
hw/nf_uart_regs.sv
hw/nf_uart.sv
verif/nf_uart_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the UART testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module nf_uart_tb -f nf_uart.f -o nf_uart_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/nf_uart_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

// File: verif/nf_uart_tb.sv
/*
 * Testbench of the UART peripheral. A table of bytes and baud compare
 * values runs through loopback, and through a serial driver that sends
 * a bad stop bit. A disable test follows the table.
 */
`timescale 1ns/1ps
`default_nettype none

`include "nf_uart_config.svh"

module nf_uart_tb
    import nf_uart_regs_pkg::*;
();

    localparam int NUM_ENTRIES  = 10;
    localparam int RESET_CYCLES = 4;
    localparam int DIS_COMP     = 9;   // baud compare of the disable test

    localparam logic [31:0] TX_BUSY_M   = 32'h1 << CTRL_TX_BUSY;
    localparam logic [31:0] RX_VALID_M  = 32'h1 << CTRL_RX_VALID;
    localparam logic [31:0] FRAME_ERR_M = 32'h1 << CTRL_FRAME_ERR;

    logic                       clk;
    logic                       resetn;
    logic [1:0]                 addr;
    logic                       we;
    logic                       re;
    logic [`NF_UART_BUS_W-1:0]  wd;
    logic [`NF_UART_BUS_W-1:0]  rd;
    logic                       uart_tx;
    logic                       rx_line;
    logic                       rx_drive;   // serial driver output
    logic                       loopback;   // uart_rx from uart_tx
    logic                       tx_line;    // uart_tx seen at the last read

    logic [7:0]                 entry_data [NUM_ENTRIES];
    logic [15:0]                entry_comp [NUM_ENTRIES];
    logic                       entry_bad_stop [NUM_ENTRIES];

    integer                     seed;
    int                         timeout_cycles;
    int                         cycle_count = 0;

    assign rx_line = loopback ? uart_tx : rx_drive;

    nf_uart dut (
        .clk     (clk),
        .resetn  (resetn),
        .addr    (addr),
        .we      (we),
        .re      (re),
        .wd      (wd),
        .rd      (rd),
        .uart_tx (uart_tx),
        .uart_rx (rx_line)
    );

    always #2 clk = ~clk;

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic [31:0] ctrl_field(input logic [31:0] ctrl,
                                               input logic [31:0] mask);
        return {31'd0, |(ctrl & mask)};
    endfunction

    task automatic set_entry(input int idx, input logic [7:0] data,
                             input logic [15:0] comp, input logic bad_stop);
        entry_data[idx]     = data;
        entry_comp[idx]     = comp;
        entry_bad_stop[idx] = bad_stop;
    endtask

    task automatic load_table();
        logic [31:0] rnd;
        set_entry(0, 8'h55, 16'd15, 1'b0);
        set_entry(1, 8'ha3, 16'd7,  1'b0);
        set_entry(2, 8'h00, 16'd5,  1'b1);
        set_entry(3, 8'hff, 16'd9,  1'b0);
        set_entry(4, 8'h81, 16'd20, 1'b1);
        set_entry(5, 8'h3c, 16'd5,  1'b0);
        for (int i = 6; i < NUM_ENTRIES; i++)
        begin
            rnd = $random(seed);
            set_entry(i, rnd[7:0], 16'(6 + 3 * (i - 6)), i == 8);
        end
    endtask

    task automatic bus_write(input logic [1:0] a, input logic [`NF_UART_BUS_W-1:0] data);
        @(negedge clk);
        addr = a;
        wd   = data;
        we   = 1'b1;
        @(negedge clk);
        we   = 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] a, output logic [`NF_UART_BUS_W-1:0] data);
        @(negedge clk);
        addr = a;
        re   = 1'b1;
        #1;
        data    = rd;       // mid low phase, well away from the edge
        tx_line = uart_tx;
        @(negedge clk);
        re   = 1'b0;
    endtask

    task automatic wait_ctrl(input logic [31:0] mask, input logic set,
                             output logic [31:0] ctrl);
        bus_read(REG_CTRL, ctrl);
        while ((|(ctrl & mask)) != set)
            bus_read(REG_CTRL, ctrl);
    endtask

    task automatic send_serial_frame(input logic [7:0] data, input int bit_cycles,
                                     input logic stop_bit);
        logic [7:0] shift;
        shift = data;
        @(negedge clk);
        rx_drive = 1'b0;  // start bit
        repeat (bit_cycles) @(negedge clk);
        repeat (8)
        begin
            rx_drive = shift[0];  // lsb first
            shift    = shift >> 1;
            repeat (bit_cycles) @(negedge clk);
        end
        rx_drive = stop_bit;
        repeat (bit_cycles) @(negedge clk);
        rx_drive = 1'b1;
    endtask

    task automatic run_loopback(input int idx);
        logic [31:0] ctrl;
        logic [31:0] data;
        bus_write(REG_COMP, {16'd0, entry_comp[idx]});
        bus_write(REG_CTRL, 32'h3);  // both sides on
        bus_write(REG_TXDATA, {24'd0, entry_data[idx]});
        bus_read(REG_CTRL, ctrl);
        check_eq("tx_busy", ctrl_field(ctrl, TX_BUSY_M), 32'd1);
        bus_write(REG_TXDATA, {24'd0, ~entry_data[idx]});  // busy, so dropped
        wait_ctrl(RX_VALID_M, 1'b1, ctrl);
        check_eq("frame_err", ctrl_field(ctrl, FRAME_ERR_M), 32'd0);
        bus_read(REG_RXDATA, data);
        check_eq("RXDATA", data, {24'd0, entry_data[idx]});
        bus_read(REG_CTRL, ctrl);
        check_eq("rx_valid", ctrl_field(ctrl, RX_VALID_M), 32'd0);
        wait_ctrl(TX_BUSY_M, 1'b0, ctrl);
        repeat (int'(entry_comp[idx]) + 1) @(negedge clk);
        bus_read(REG_CTRL, ctrl);
        check_eq("rx_valid", ctrl_field(ctrl, RX_VALID_M), 32'd0);  // no second frame
    endtask

    task automatic run_bad_stop(input int idx);
        logic [31:0] ctrl;
        logic [31:0] data;
        bus_write(REG_COMP, {16'd0, entry_comp[idx]});
        bus_write(REG_CTRL, 32'h2);  // receiver only
        loopback = 1'b0;
        send_serial_frame(entry_data[idx], int'(entry_comp[idx]) + 1, 1'b0);
        wait_ctrl(RX_VALID_M, 1'b1, ctrl);
        check_eq("frame_err", ctrl_field(ctrl, FRAME_ERR_M), 32'd1);
        bus_read(REG_RXDATA, data);
        check_eq("RXDATA", data, {24'd0, entry_data[idx]});
        loopback = 1'b1;
    endtask

    task automatic run_disable();
        logic [31:0] ctrl;
        bus_write(REG_COMP, 32'(DIS_COMP));
        bus_write(REG_CTRL, 32'h3);
        bus_write(REG_TXDATA, 32'h3c);  // bits 0 and 1 low
        while (uart_tx !== 1'b0)
            @(negedge clk);
        repeat (3 * (DIS_COMP + 1) / 2) @(negedge clk);  // middle of bit 0
        check_eq("uart_tx", {31'd0, uart_tx}, 32'd0);
        bus_write(REG_CTRL, 32'h0);
        bus_read(REG_CTRL, ctrl);  // sampled within 2 cycles of the write edge
        check_eq("uart_tx", {31'd0, tx_line}, 32'd1);
        check_eq("tx_busy", ctrl_field(ctrl, TX_BUSY_M), 32'd0);
        repeat (12 * (DIS_COMP + 1)) @(negedge clk);
        bus_read(REG_CTRL, ctrl);
        check_eq("rx_valid", ctrl_field(ctrl, RX_VALID_M), 32'd0);
    endtask

    initial
    begin : watchdog
        @(posedge clk);
        while (cycle_count < timeout_cycles)
        begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", cycle_count);
        $display("Test failures found");
        $fatal(1, "simulation aborted");
    end

    initial
    begin
        logic [31:0] rd_val;
        clk      = 1'b0;
        resetn   = 1'b0;
        addr     = 2'd0;
        we       = 1'b0;
        re       = 1'b0;
        wd       = '0;
        rx_drive = 1'b1;
        loopback = 1'b1;
        tx_line  = 1'b1;
        seed     = 32'ha366;
        load_table();
        timeout_cycles = RESET_CYCLES + 20 * (DIS_COMP + 1) + 50;
        for (int i = 0; i < NUM_ENTRIES; i++)
            timeout_cycles += 12 * (int'(entry_comp[i]) + 1) + 50;

        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        check_eq("uart_tx", {31'd0, uart_tx}, 32'd1);
        bus_read(REG_CTRL, rd_val);
        check_eq("CTRL", rd_val, 32'd0);
        bus_read(REG_COMP, rd_val);
        check_eq("COMP", rd_val, 32'(`NF_UART_COMP_RST));

        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            if (entry_bad_stop[i])
                run_bad_stop(i);
            else
                run_loopback(i);
        end
        run_disable();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
